//--- hdl/sd_cache_params.svh
// Width, bank and way parameters of the SD block cache manager
// Card and DMA address widths, block and sector sizes
// Tag and entry number widths derived from index and way bits

`ifndef SD_CACHE_PARAMS_SVH
`define SD_CACHE_PARAMS_SVH

// ======================================================================
// Addresses
// ======================================================================

// Card and DMA address width
`define SD_ADDR_W 32

// Physical block number width
`define BLOCK_W 20

// Byte offset inside a 512-byte block
`define SECTOR_OFFSET_W 9

// ======================================================================
// Cache geometry
// ======================================================================

// One tag bank per index
`define INDEX_W 2
`define NUM_BANKS (1 << `INDEX_W)

// Ways held in each bank
`define WAY_W 2
`define NUM_WAYS (1 << `WAY_W)

`define TAG_W (`BLOCK_W - `INDEX_W)

// Entry number is the way over the index
`define ENTRY_W (`INDEX_W + `WAY_W)

`endif

//--- hdl/sd_cache_pkg.sv
// Shared types of the SD block cache manager
// Request word union, bank and lookup results, tag update, card command

`include "sd_cache_params.svh"

package sd_cache_pkg;

    // Tag over index view of a block number
    typedef struct packed {
        logic [`TAG_W-1:0]   tag;
        logic [`INDEX_W-1:0] index;
    } blk_fields_t;

    // Request word, read flat for the card address and split for the banks
    typedef union packed {
        logic [`BLOCK_W-1:0] blk;
        blk_fields_t         f;
    } blk_req_u;

    // Result of one bank, way is the hit way or the victim way on a miss
    typedef struct packed {
        logic              hit;
        logic              dirty;
        logic [`WAY_W-1:0] way;
        logic [`TAG_W-1:0] tag;
    } bank_res_t;

    // Merged lookup result for the requested index
    typedef struct packed {
        logic                hit;
        logic                dirty;
        logic [`ENTRY_W-1:0] entry;
        logic [`BLOCK_W-1:0] victim_blk;
    } lkp_res_t;

    // Tag write broadcast to all banks
    typedef struct packed {
        logic                we;
        logic [`INDEX_W-1:0] index;
        logic [`WAY_W-1:0]   way;
        logic [`TAG_W-1:0]   tag;
        logic                dirty;
        logic                alloc;
    } tag_upd_t;

    // Block transfer command to the transaction manager
    typedef struct packed {
        logic                  wr;
        logic [`SD_ADDR_W-1:0] sd_addr;
        logic [`SD_ADDR_W-1:0] dma_addr;
    } sd_cmd_t;

endpackage

//--- hdl/sd_tag_bank.sv
// Tag bank for one cache index
// Valid, dirty and tag bits per way
// Combinational lookup with round-robin victim selection, one-cycle write

`include "sd_cache_params.svh"

module sd_tag_bank #(
    parameter int BANK_ID = 0
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [`TAG_W-1:0]       lkp_tag,
    input  sd_cache_pkg::tag_upd_t  upd,
    output sd_cache_pkg::bank_res_t res
);

    logic [`NUM_WAYS-1:0] valid;
    logic [`NUM_WAYS-1:0] dirty;
    logic [`TAG_W-1:0]    tags [`NUM_WAYS];
    logic [`WAY_W-1:0]    rr_ptr;
    logic                 hit;
    logic [`WAY_W-1:0]    hit_way;
    logic [`WAY_W-1:0]    sel_way;
    logic                 bank_we;

    // ======================================================================
    // Lookup
    // ======================================================================

    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = 0; w < `NUM_WAYS; w++) begin
            if (valid[w] && (tags[w] == lkp_tag)) begin
                hit     = 1'b1;
                hit_way = w[`WAY_W-1:0];
            end
        end
    end

    // Victim is the way under the pointer, valid or not
    assign sel_way = hit ? hit_way : rr_ptr;

    always_comb begin
        res.hit   = hit;
        res.way   = sel_way;
        res.tag   = tags[sel_way];
        res.dirty = valid[sel_way] & dirty[sel_way];
    end

    // ======================================================================
    // Update
    // ======================================================================

    assign bank_we = upd.we && (int'(upd.index) == BANK_ID);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid  <= '0;
            dirty  <= '0;
            rr_ptr <= '0;
        end else if (bank_we) begin
            valid[upd.way] <= 1'b1;
            // A fill starts clean unless the core writes, a hit only adds dirt
            if (upd.alloc) begin
                dirty[upd.way] <= upd.dirty;
                rr_ptr         <= rr_ptr + 1'b1;
            end else begin
                dirty[upd.way] <= dirty[upd.way] | upd.dirty;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (bank_we) begin
            tags[upd.way] <= upd.tag;
        end
    end

endmodule

//--- hdl/sd_lookup_merge.sv
// Lookup merge stage
// Picks the bank result for the requested index
// Builds the entry number and the victim block number

`include "sd_cache_params.svh"

module sd_lookup_merge (
    input  sd_cache_pkg::blk_req_u                   req,
    input  sd_cache_pkg::bank_res_t [`NUM_BANKS-1:0] bank_res,
    output sd_cache_pkg::lkp_res_t                   res
);

    import sd_cache_pkg::*;

    bank_res_t           sel;
    logic [`INDEX_W-1:0] index;

    assign index = req.f.index;
    assign sel   = bank_res[index];

    always_comb begin
        res.hit   = sel.hit;
        res.dirty = sel.dirty;
        // Way over index
        res.entry = {sel.way, index};
        // Victim tag goes back over its index to give the block number
        res.victim_blk = {sel.tag, index};
    end

endmodule

//--- hdl/sd_cache_ctrl.sv
// Cache controller
// Lock handling and the main FSM
// Writeback and fill command generation with card address formatting
// Tag update for hits and allocations

`include "sd_cache_params.svh"

module sd_cache_ctrl (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   lock_acquire,
    input  logic                   lock_release,
    output logic                   lock_status,
    input  logic                   core_we,
    input  logic [`BLOCK_W-1:0]    core_block,
    output logic                   core_rdy,
    output logic [`ENTRY_W-1:0]    core_entry,
    output sd_cache_pkg::blk_req_u lkp_req,
    input  sd_cache_pkg::lkp_res_t lkp_res,
    output sd_cache_pkg::tag_upd_t upd,
    output sd_cache_pkg::sd_cmd_t  tm_cmd,
    output logic                   tm_cmd_valid,
    input  logic                   tm_cmd_ready,
    input  logic                   tm_rsp_valid,
    input  logic                   tm_rsp_ok,
    output logic                   tm_rsp_ready,
    input  logic                   is_hcxc
);

    import sd_cache_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        WB_ISSUE,
        WB_WAIT,
        FILL_ISSUE,
        FILL_WAIT,
        UPDATE,
        LOCKED
    } state_t;

    state_t                state;
    state_t                state_next;
    logic                  core_we_f;
    lkp_res_t              res_f;
    logic                  take;
    logic                  release_go;
    logic                  cmd_go;
    logic                  rsp_go;
    logic [`SD_ADDR_W-1:0] dma_addr;

    // High-capacity cards take block numbers, standard cards byte addresses
    function automatic logic [`SD_ADDR_W-1:0] card_addr(
        input logic [`BLOCK_W-1:0] blk,
        input logic                hcxc
    );
        logic [`SD_ADDR_W-1:0] ext;
        ext = {{(`SD_ADDR_W - `BLOCK_W){1'b0}}, blk};
        return hcxc ? ext : (ext << `SECTOR_OFFSET_W);
    endfunction

    assign take       = (state == IDLE) && lock_acquire && !lock_status;
    assign release_go = core_rdy && lock_release;
    assign cmd_go     = tm_cmd_valid && tm_cmd_ready;
    assign rsp_go     = tm_rsp_ready && tm_rsp_valid;

    // ======================================================================
    // Registers
    // ======================================================================

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state       <= IDLE;
            lock_status <= 1'b0;
        end else begin
            state <= state_next;
            if (take) begin
                lock_status <= 1'b1;
            end else if (release_go) begin
                lock_status <= 1'b0;
            end
        end
    end

    // Request captured at grant, lookup result held from LOOKUP on
    always_ff @(posedge clk) begin
        if (take) begin
            lkp_req.blk <= core_block;
            core_we_f   <= core_we;
        end
        if (state == LOOKUP) begin
            res_f <= lkp_res;
        end
    end

    // ======================================================================
    // FSM
    // ======================================================================

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (take) begin
                    state_next = LOOKUP;
                end
            end
            LOOKUP: begin
                if (lkp_res.hit) begin
                    state_next = UPDATE;
                end else if (lkp_res.dirty) begin
                    state_next = WB_ISSUE;
                end else begin
                    state_next = FILL_ISSUE;
                end
            end
            WB_ISSUE: begin
                if (cmd_go) begin
                    state_next = WB_WAIT;
                end
            end
            WB_WAIT: begin
                // Not-ok sends the same writeback again
                if (rsp_go) begin
                    state_next = tm_rsp_ok ? FILL_ISSUE : WB_ISSUE;
                end
            end
            FILL_ISSUE: begin
                if (cmd_go) begin
                    state_next = FILL_WAIT;
                end
            end
            FILL_WAIT: begin
                if (rsp_go) begin
                    state_next = tm_rsp_ok ? UPDATE : FILL_ISSUE;
                end
            end
            UPDATE: begin
                state_next = lock_release ? IDLE : LOCKED;
            end
            LOCKED: begin
                if (lock_release) begin
                    state_next = IDLE;
                end
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    // ======================================================================
    // Outputs
    // ======================================================================

    assign core_rdy     = (state == UPDATE) || (state == LOCKED);
    assign core_entry   = res_f.entry;
    assign tm_cmd_valid = (state == WB_ISSUE) || (state == FILL_ISSUE);
    assign tm_rsp_ready = (state == WB_WAIT) || (state == FILL_WAIT);

    // Slot in the DMA buffer, one 512-byte block per entry
    assign dma_addr = {{(`SD_ADDR_W - `SECTOR_OFFSET_W - `ENTRY_W){1'b0}},
                       res_f.entry, {`SECTOR_OFFSET_W{1'b0}}};

    always_comb begin
        tm_cmd.wr       = (state == WB_ISSUE);
        tm_cmd.dma_addr = dma_addr;
        if (state == WB_ISSUE) begin
            tm_cmd.sd_addr = card_addr(res_f.victim_blk, is_hcxc);
        end else begin
            tm_cmd.sd_addr = card_addr(lkp_req.blk, is_hcxc);
        end
    end

    // Written in the first ready cycle, an allocation on a miss
    always_comb begin
        upd.we    = (state == UPDATE);
        upd.index = lkp_req.f.index;
        upd.way   = res_f.entry[`ENTRY_W-1:`INDEX_W];
        upd.tag   = lkp_req.f.tag;
        upd.dirty = core_we_f;
        upd.alloc = !res_f.hit;
    end

endmodule

//--- hdl/sd_cache_manager.sv
// Top level of the SD block cache manager
// Controller, one tag bank per index, and the lookup merge stage

`include "sd_cache_params.svh"

module sd_cache_manager (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  lock_acquire,
    input  logic                  lock_release,
    output logic                  lock_status,
    input  logic                  core_we,
    input  logic [`BLOCK_W-1:0]   core_block,
    output logic                  core_rdy,
    output logic [`ENTRY_W-1:0]   core_entry,
    output sd_cache_pkg::sd_cmd_t tm_cmd,
    output logic                  tm_cmd_valid,
    input  logic                  tm_cmd_ready,
    input  logic                  tm_rsp_valid,
    input  logic                  tm_rsp_ok,
    output logic                  tm_rsp_ready,
    input  logic                  is_hcxc
);

    import sd_cache_pkg::*;

    blk_req_u                    lkp_req;
    lkp_res_t                    lkp_res;
    tag_upd_t                    upd;
    bank_res_t [`NUM_BANKS-1:0]  bank_res;

    sd_cache_ctrl u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .lock_acquire (lock_acquire),
        .lock_release (lock_release),
        .lock_status  (lock_status),
        .core_we      (core_we),
        .core_block   (core_block),
        .core_rdy     (core_rdy),
        .core_entry   (core_entry),
        .lkp_req      (lkp_req),
        .lkp_res      (lkp_res),
        .upd          (upd),
        .tm_cmd       (tm_cmd),
        .tm_cmd_valid (tm_cmd_valid),
        .tm_cmd_ready (tm_cmd_ready),
        .tm_rsp_valid (tm_rsp_valid),
        .tm_rsp_ok    (tm_rsp_ok),
        .tm_rsp_ready (tm_rsp_ready),
        .is_hcxc      (is_hcxc)
    );

    // Every bank sees the same tag and update, each keeps its own index
    for (genvar i = 0; i < `NUM_BANKS; i++) begin : g_bank
        sd_tag_bank #(
            .BANK_ID (i)
        ) u_bank (
            .clk     (clk),
            .rst     (rst),
            .lkp_tag (lkp_req.f.tag),
            .upd     (upd),
            .res     (bank_res[i])
        );
    end

    sd_lookup_merge u_merge (
        .req      (lkp_req),
        .bank_res (bank_res),
        .res      (lkp_res)
    );

endmodule

//--- verif/sd_cache_chk.sv
// Concurrent checks on the SD cache manager ports
// Command stability under back-pressure, one channel active at a time,
// ready only while locked

module sd_cache_chk (
    input logic                  clk,
    input logic                  rst,
    input logic                  lock_status,
    input logic                  core_rdy,
    input sd_cache_pkg::sd_cmd_t tm_cmd,
    input logic                  tm_cmd_valid,
    input logic                  tm_cmd_ready,
    input logic                  tm_rsp_ready
);

    timeunit 1ns;
    timeprecision 1ps;

    // A stalled command stays valid and unchanged
    cmd_stable: assert property (@(posedge clk) disable iff (rst)
        tm_cmd_valid && !tm_cmd_ready |=> tm_cmd_valid && $stable(tm_cmd))
        else $error("tm_cmd changed or dropped while stalled");

    cmd_rsp_excl: assert property (@(posedge clk) disable iff (rst)
        !(tm_cmd_valid && tm_rsp_ready))
        else $error("tm_cmd_valid and tm_rsp_ready high together");

    rdy_locked: assert property (@(posedge clk) disable iff (rst)
        core_rdy |-> lock_status)
        else $error("core_rdy high without the lock");

endmodule

bind sd_cache_manager sd_cache_chk u_chk (
    .clk          (clk),
    .rst          (rst),
    .lock_status  (lock_status),
    .core_rdy     (core_rdy),
    .tm_cmd       (tm_cmd),
    .tm_cmd_valid (tm_cmd_valid),
    .tm_cmd_ready (tm_cmd_ready),
    .tm_rsp_ready (tm_rsp_ready)
);

//--- verif/tb_sd_cache.sv
// Testbench of the SD block cache manager
// Random core requests and transaction manager with stalls and retries
// Reference tag model with round-robin victims per bank
// Checks lock timing, hits, clean and dirty misses, both card address modes

`include "sd_cache_params.svh"

module tb_sd_cache;

    timeunit 1ns;
    timeprecision 1ps;

    import sd_cache_pkg::*;

    localparam int NUM_TRANS = 300;
    localparam int TIMEOUT   = 50;

    logic                clk;
    logic                rst;
    logic                lock_acquire;
    logic                lock_release;
    logic                lock_status;
    logic                core_we;
    logic [`BLOCK_W-1:0] core_block;
    logic                core_rdy;
    logic [`ENTRY_W-1:0] core_entry;
    sd_cmd_t             tm_cmd;
    logic                tm_cmd_valid;
    logic                tm_cmd_ready;
    logic                tm_rsp_valid;
    logic                tm_rsp_ok;
    logic                tm_rsp_ready;
    logic                is_hcxc;
    integer              seed;

    // Reference tag state per bank and way
    logic                m_valid [`NUM_BANKS][`NUM_WAYS];
    logic                m_dirty [`NUM_BANKS][`NUM_WAYS];
    logic [`TAG_W-1:0]   m_tag   [`NUM_BANKS][`NUM_WAYS];
    logic [`WAY_W-1:0]   m_ptr   [`NUM_BANKS];

    sd_cache_manager UUT (
        .clk          (clk),
        .rst          (rst),
        .lock_acquire (lock_acquire),
        .lock_release (lock_release),
        .lock_status  (lock_status),
        .core_we      (core_we),
        .core_block   (core_block),
        .core_rdy     (core_rdy),
        .core_entry   (core_entry),
        .tm_cmd       (tm_cmd),
        .tm_cmd_valid (tm_cmd_valid),
        .tm_cmd_ready (tm_cmd_ready),
        .tm_rsp_valid (tm_rsp_valid),
        .tm_rsp_ok    (tm_rsp_ok),
        .tm_rsp_ready (tm_rsp_ready),
        .is_hcxc      (is_hcxc)
    );

    always #10 clk = ~clk;

    // ======================================================================
    // Reporting
    // ======================================================================

    task automatic stop_failed();
        $display("TEST FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic abort_run(input string what);
        $display("ERROR at %0t ns: %s", $time, what);
        stop_failed();
    endtask

    task automatic check(input string name, input logic [71:0] got, input logic [71:0] exp);
        assert (got === exp) else begin
            $display("CHECK FAILED at %0t ns: %s got %0h expected %0h", $time, name, got, exp);
            stop_failed();
        end
    endtask

    // ======================================================================
    // Address rules
    // ======================================================================

    // Block number on high-capacity cards, byte address otherwise
    function automatic logic [`SD_ADDR_W-1:0] expect_card_addr(input logic [`BLOCK_W-1:0] blk);
        logic [`SD_ADDR_W-1:0] n;
        n = '0;
        n[`BLOCK_W-1:0] = blk;
        return is_hcxc ? n : n * 512;
    endfunction

    function automatic logic [`SD_ADDR_W-1:0] expect_dma_addr(input logic [`ENTRY_W-1:0] entry);
        logic [`SD_ADDR_W-1:0] n;
        n = '0;
        n[`ENTRY_W-1:0] = entry;
        return n * 512;
    endfunction

    // ======================================================================
    // Transaction manager model
    // ======================================================================

    task automatic wait_cmd_valid();
        int n;
        n = 0;
        while (!tm_cmd_valid && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!tm_cmd_valid) begin
            abort_run("no command from the DUT within the timeout");
        end
    endtask

    task automatic wait_rsp_ready();
        int n;
        n = 0;
        while (!tm_rsp_ready && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!tm_rsp_ready) begin
            abort_run("DUT never became ready for the response");
        end
    endtask

    // Accept one command, answer it, and repeat on not-ok until ok
    task automatic serve_cmd(input sd_cmd_t exp);
        int   stall;
        int   delay;
        logic ok;
        ok = 1'b0;
        while (!ok) begin
            wait_cmd_valid();
            stall = $unsigned($random(seed)) % 4;
            repeat (stall) begin
                check("tm_cmd", 72'(tm_cmd), 72'(exp));
                @(negedge clk);
            end
            check("tm_cmd", 72'(tm_cmd), 72'(exp));
            tm_cmd_ready = 1'b1;
            @(negedge clk);
            tm_cmd_ready = 1'b0;
            check("tm_cmd_valid", 72'(tm_cmd_valid), 72'(1'b0));
            wait_rsp_ready();
            delay = $unsigned($random(seed)) % 4;
            repeat (delay) @(negedge clk);
            // Roughly one answer in four is not-ok
            ok = (($random(seed) & 3) != 0);
            tm_rsp_valid = 1'b1;
            tm_rsp_ok    = ok;
            @(negedge clk);
            tm_rsp_valid = 1'b0;
            tm_rsp_ok    = 1'b0;
        end
    endtask

    // ======================================================================
    // Core model
    // ======================================================================

    task automatic run_transaction();
        logic [`TAG_W-1:0]   tag;
        logic [`INDEX_W-1:0] idx;
        logic [`BLOCK_W-1:0] blk;
        logic                we;
        logic                hit;
        logic [`WAY_W-1:0]   way;
        logic [`ENTRY_W-1:0] entry;
        logic [`BLOCK_W-1:0] victim;
        sd_cmd_t             cmd;
        int                  gap;

        // Eight tags per bank against four ways forces evictions
        tag = {3'($random(seed)), 15'h1a5c};
        idx = 2'($random(seed));
        blk = {tag, idx};
        we  = 1'($random(seed));
        gap = $unsigned($random(seed)) % 4;
        repeat (gap) @(negedge clk);

        hit = 1'b0;
        way = m_ptr[idx];
        for (int w = 0; w < `NUM_WAYS; w++) begin
            if (m_valid[idx][w] && m_tag[idx][w] == tag) begin
                hit = 1'b1;
                way = w[`WAY_W-1:0];
            end
        end
        entry  = {way, idx};
        victim = {m_tag[idx][way], idx};

        lock_acquire = 1'b1;
        core_block   = blk;
        core_we      = we;
        @(negedge clk);
        check("lock_status", 72'(lock_status), 72'(1'b1));
        check("core_rdy", 72'(core_rdy), 72'(1'b0));
        check("tm_cmd_valid", 72'(tm_cmd_valid), 72'(1'b0));
        // Request inputs are don't-care after the grant
        lock_acquire = 1'($random(seed));
        core_block   = 20'($random(seed));
        core_we      = 1'($random(seed));
        @(negedge clk);

        if (hit) begin
            check("core_rdy", 72'(core_rdy), 72'(1'b1));
        end else begin
            check("core_rdy", 72'(core_rdy), 72'(1'b0));
            cmd.dma_addr = expect_dma_addr(entry);
            if (m_valid[idx][way] && m_dirty[idx][way]) begin
                cmd.wr      = 1'b1;
                cmd.sd_addr = expect_card_addr(victim);
                serve_cmd(cmd);
            end
            cmd.wr      = 1'b0;
            cmd.sd_addr = expect_card_addr(blk);
            serve_cmd(cmd);
            check("core_rdy", 72'(core_rdy), 72'(1'b1));
        end
        check("core_entry", 72'(core_entry), 72'(entry));
        check("tm_cmd_valid", 72'(tm_cmd_valid), 72'(1'b0));

        if (hit) begin
            m_dirty[idx][way] = m_dirty[idx][way] | we;
        end else begin
            m_valid[idx][way] = 1'b1;
            m_tag[idx][way]   = tag;
            m_dirty[idx][way] = we;
            m_ptr[idx]        = m_ptr[idx] + 1'b1;
        end

        // Hold the lock a while, acquire pulses must not disturb it
        gap = $unsigned($random(seed)) % 4;
        repeat (gap) begin
            lock_acquire = 1'($random(seed));
            @(negedge clk);
            check("lock_status", 72'(lock_status), 72'(1'b1));
            check("core_rdy", 72'(core_rdy), 72'(1'b1));
            check("core_entry", 72'(core_entry), 72'(entry));
        end
        lock_acquire = 1'b0;
        lock_release = 1'b1;
        @(negedge clk);
        lock_release = 1'b0;
        check("lock_status", 72'(lock_status), 72'(1'b0));
        check("core_rdy", 72'(core_rdy), 72'(1'b0));
    endtask

    // ======================================================================
    // Main sequence
    // ======================================================================

    initial begin
        seed         = 32'hee6ead00;
        clk          = 1'b0;
        rst          = 1'b1;
        lock_acquire = 1'b0;
        lock_release = 1'b0;
        core_we      = 1'b0;
        core_block   = '0;
        tm_cmd_ready = 1'b0;
        tm_rsp_valid = 1'b0;
        tm_rsp_ok    = 1'b0;
        is_hcxc      = 1'b0;
        for (int b = 0; b < `NUM_BANKS; b++) begin
            m_ptr[b] = '0;
            for (int w = 0; w < `NUM_WAYS; w++) begin
                m_valid[b][w] = 1'b0;
                m_dirty[b][w] = 1'b0;
                m_tag[b][w]   = '0;
            end
        end

        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check("lock_status", 72'(lock_status), 72'(1'b0));
        check("core_rdy", 72'(core_rdy), 72'(1'b0));
        check("tm_cmd_valid", 72'(tm_cmd_valid), 72'(1'b0));
        check("tm_rsp_ready", 72'(tm_rsp_ready), 72'(1'b0));

        // Standard card first, then high-capacity
        for (int t = 0; t < NUM_TRANS; t++) begin
            if (t == NUM_TRANS / 2) begin
                is_hcxc = 1'b1;
            end
            run_transaction();
        end

        $display("TEST PASSED");
        $finish;
    end

endmodule

//--- tb.f
+incdir+hdl
hdl/sd_cache_pkg.sv
hdl/sd_tag_bank.sv
hdl/sd_lookup_merge.sv
hdl/sd_cache_ctrl.sv
hdl/sd_cache_manager.sv
verif/sd_cache_chk.sv
verif/tb_sd_cache.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the SD cache manager testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -f tb.f --top-module tb_sd_cache -o sim_tb

out=$(./obj_dir/sim_tb 2>&1 || true)
echo "$out"

if echo "$out" | grep -q "^TEST PASSED$"; then
    exit 0
fi
exit 1
